// ==== common/cpu_pkg.sv ====
package cpu_pkg;

	localparam int opcode_w  = 6;
	localparam int reg_idx_w = 5;
	localparam int sub_op_w  = 5;
	localparam int imm14_w   = 14;
	localparam int imm20_w   = 20;
	localparam int data_w    = 32;

	// instruction classes, any other code is a no-op.
	typedef enum logic [opcode_w-1:0] {
		op_alu  = 6'h20,
		op_addi = 6'h28,
		op_movi = 6'h22,
		op_lwi  = 6'h02,
		op_swi  = 6'h0a
	} opcode_e;

	// sub_op_base codes of register alu operations.
	typedef enum logic [sub_op_w-1:0] {
		alu_add = 5'h00,
		alu_sub = 5'h01,
		alu_and = 5'h02,
		alu_xor = 5'h03,
		alu_or  = 5'h04,
		alu_slt = 5'h06
	} alu_op_e;

	typedef enum logic [1:0] {
		wb_alu = 2'b00,
		wb_mem = 2'b01
	} wb_sel_e;

endpackage

// ==== design/instr_queue.sv ====
`timescale 1ns/10ps

module instr_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic        clock,
	input  logic        arst_n,
	input  logic        instr_valid,
	input  logic [31:0] instr,
	input  logic        stall,
	output logic        pop_valid,
	output logic [31:0] pop_instr,
	output logic        credit_return
);
	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	logic [31:0] entries [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign pop_valid     = (count != '0) && !stall;
	assign pop_instr     = entries[rd_ptr];
	assign credit_return = pop_valid; // one credit back per pop.

	always_ff @(posedge clock) begin
		if (instr_valid)
			entries[wr_ptr] <= instr;
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (instr_valid)
				wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_valid)
				rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// source never pushes without a credit, so no overflow.
			count <= count + CNT_W'(instr_valid) - CNT_W'(pop_valid);
		end
	end

endmodule

// ==== decode/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
	input  logic        clock,
	input  logic        arst_n,
	input  logic [4:0]  ra_idx,
	input  logic [4:0]  src2_idx,
	output logic [31:0] ra_data,
	output logic [31:0] src2_data,
	input  logic        wr_en,
	input  logic [4:0]  wr_idx,
	input  logic [31:0] wr_data
);
	logic [31:0] regs [32];

	assign ra_data   = regs[ra_idx];
	assign src2_data = regs[src2_idx];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

endmodule

// ==== decode/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
	input  logic                                in_valid,
	input  logic [cpu_pkg::data_w-1:0]          instr,
	output logic [cpu_pkg::reg_idx_w-1:0]       ra_idx,
	output logic [cpu_pkg::reg_idx_w-1:0]       src2_idx,
	input  logic [cpu_pkg::data_w-1:0]          rf_ra_data,
	input  logic [cpu_pkg::data_w-1:0]          rf_src2_data,
	input  logic                                ex_is_load,
	input  logic [cpu_pkg::reg_idx_w-1:0]       ex_wr_idx,
	input  logic                                res_do_reg_write,
	input  logic [cpu_pkg::reg_idx_w-1:0]       res_wr_idx,
	input  logic [cpu_pkg::data_w-1:0]          res_data,
	input  logic                                wb_do_reg_write,
	input  logic [cpu_pkg::reg_idx_w-1:0]       wb_wr_idx,
	input  logic [cpu_pkg::data_w-1:0]          wb_data,
	output cpu_pkg::opcode_e                    opcode,
	output cpu_pkg::alu_op_e                    alu_op,
	output cpu_pkg::wb_sel_e                    wb_sel,
	output logic [cpu_pkg::data_w-1:0]          ra_data,
	output logic [cpu_pkg::data_w-1:0]          rt_data,
	output logic [cpu_pkg::data_w-1:0]          alu_src2,
	output logic [cpu_pkg::reg_idx_w-1:0]       wr_idx,
	output logic                                do_dm_read,
	output logic                                do_dm_write,
	output logic                                do_reg_write,
	output logic                                stall
);
	logic [cpu_pkg::reg_idx_w-1:0] rt_idx;
	logic [cpu_pkg::reg_idx_w-1:0] rb_idx;
	logic [cpu_pkg::data_w-1:0]    imm14_ext;
	logic [cpu_pkg::data_w-1:0]    imm20_ext;
	logic                          uses_ra;
	logic                          uses_src2;

	// newest value wins.
	function automatic logic [cpu_pkg::data_w-1:0] bypass(
		input logic [cpu_pkg::reg_idx_w-1:0] idx,
		input logic [cpu_pkg::data_w-1:0]    rf_data
	);
		if (res_do_reg_write && res_wr_idx == idx)
			return res_data;
		if (wb_do_reg_write && wb_wr_idx == idx)
			return wb_data;
		return rf_data;
	endfunction

	assign opcode    = cpu_pkg::opcode_e'(instr[30:25]);
	assign rt_idx    = instr[24:20];
	assign ra_idx    = instr[19:15];
	assign rb_idx    = instr[14:10];
	assign src2_idx  = (opcode == cpu_pkg::op_swi) ? rt_idx : rb_idx; // store data source.
	assign wr_idx    = rt_idx;
	assign imm14_ext = {{(cpu_pkg::data_w - cpu_pkg::imm14_w){instr[13]}}, instr[13:0]};
	assign imm20_ext = {{(cpu_pkg::data_w - cpu_pkg::imm20_w){instr[19]}}, instr[19:0]};

	always_comb begin
		ra_data      = bypass(ra_idx, rf_ra_data);
		rt_data      = bypass(src2_idx, rf_src2_data);
		alu_op       = cpu_pkg::alu_add;
		wb_sel       = cpu_pkg::wb_alu;
		alu_src2     = imm14_ext;
		do_dm_read   = 1'b0;
		do_dm_write  = 1'b0;
		do_reg_write = 1'b0;
		uses_ra      = 1'b0;
		uses_src2    = 1'b0;
		case (opcode)
			cpu_pkg::op_alu: begin
				alu_op       = cpu_pkg::alu_op_e'(instr[4:0]);
				alu_src2     = rt_data;
				do_reg_write = in_valid;
				uses_ra      = 1'b1;
				uses_src2    = 1'b1;
			end
			cpu_pkg::op_addi: begin
				do_reg_write = in_valid;
				uses_ra      = 1'b1;
			end
			cpu_pkg::op_movi: begin
				alu_src2     = imm20_ext;
				do_reg_write = in_valid;
			end
			cpu_pkg::op_lwi: begin
				wb_sel       = cpu_pkg::wb_mem;
				do_dm_read   = in_valid;
				do_reg_write = in_valid;
				uses_ra      = 1'b1;
			end
			cpu_pkg::op_swi: begin
				do_dm_write = in_valid;
				uses_ra     = 1'b1;
				uses_src2   = 1'b1;
			end
			default: ; // no-op.
		endcase
	end

	// result still in execute, one bubble lets the result stage bypass it.
	assign stall = in_valid && ex_is_load &&
		((uses_ra && ex_wr_idx == ra_idx) || (uses_src2 && ex_wr_idx == src2_idx));

endmodule

// ==== execute/alu.sv ====
`timescale 1ns/10ps

module alu (
	input  cpu_pkg::alu_op_e                alu_op,
	input  cpu_pkg::opcode_e                opcode,
	input  logic [cpu_pkg::data_w-1:0]      src1,
	input  logic [cpu_pkg::data_w-1:0]      src2,
	output logic [cpu_pkg::data_w-1:0]      result,
	output logic                            overflow
);
	logic [cpu_pkg::data_w-1:0] sum;
	logic [cpu_pkg::data_w-1:0] diff;
	logic                       add_ovf;
	logic                       sub_ovf;
	logic                       arith;

	assign sum     = src1 + src2;
	assign diff    = src1 - src2;
	assign add_ovf = (src1[31] == src2[31]) && (sum[31] != src1[31]);
	assign sub_ovf = (src1[31] != src2[31]) && (diff[31] != src1[31]);
	// address adds of loads and stores carry no flag.
	assign arith   = (opcode == cpu_pkg::op_alu) || (opcode == cpu_pkg::op_addi);

	always_comb begin
		overflow = 1'b0;
		if (opcode == cpu_pkg::op_movi) begin
			result = src2;
		end else begin
			case (alu_op)
				cpu_pkg::alu_add: begin
					result   = sum;
					overflow = arith && add_ovf;
				end
				cpu_pkg::alu_sub: begin
					result   = diff;
					overflow = arith && sub_ovf;
				end
				cpu_pkg::alu_and: result = src1 & src2;
				cpu_pkg::alu_or:  result = src1 | src2;
				cpu_pkg::alu_xor: result = src1 ^ src2;
				cpu_pkg::alu_slt: result = {31'b0, $signed(src1) < $signed(src2)};
				default:          result = '0; // undefined sub-op.
			endcase
		end
	end

endmodule

// ==== result/result_stage.sv ====
`timescale 1ns/10ps

module result_stage #(
	parameter int DMEM_WORDS = 64
) (
	input  logic                         clock,
	input  logic [cpu_pkg::data_w-1:0]   alu_result,
	input  logic [cpu_pkg::data_w-1:0]   store_data,
	input  logic                         do_dm_read,
	input  logic                         do_dm_write,
	input  cpu_pkg::wb_sel_e             wb_sel,
	output logic [cpu_pkg::data_w-1:0]   write_reg_data
);
	localparam int ADDR_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

	logic [cpu_pkg::data_w-1:0] dmem [DMEM_WORDS];
	logic [ADDR_W-1:0]          addr;
	logic [cpu_pkg::data_w-1:0] mem_data;

	assign addr     = alu_result[ADDR_W-1:0]; // word address, upper bits ignored.
	assign mem_data = do_dm_read ? dmem[addr] : '0;

	always_ff @(posedge clock) begin
		if (do_dm_write)
			dmem[addr] <= store_data;
	end

	assign write_reg_data = (wb_sel == cpu_pkg::wb_mem) ? mem_data : alu_result;

endmodule

// ==== design/pipe_walls.sv ====
`timescale 1ns/10ps

module pipe_walls (
	input  logic                           clock,
	input  logic                           arst_n,
	input  logic                           hold1,
	input  logic                           bubble2,
	// REG1
	input  logic                           in_reg1_valid,
	input  logic [cpu_pkg::data_w-1:0]     in_reg1_instr,
	output logic                           out_reg1_valid,
	output logic [cpu_pkg::data_w-1:0]     out_reg1_instr,
	// REG2
	input  logic [cpu_pkg::data_w-1:0]     in_reg2_ra_data,
	input  logic [cpu_pkg::data_w-1:0]     in_reg2_rt_data,
	input  logic [cpu_pkg::data_w-1:0]     in_reg2_alu_src2,
	input  cpu_pkg::opcode_e               in_reg2_opcode,
	input  cpu_pkg::alu_op_e               in_reg2_alu_op,
	input  logic [cpu_pkg::reg_idx_w-1:0]  in_reg2_wr_idx,
	input  cpu_pkg::wb_sel_e               in_reg2_wb_sel,
	input  logic                           in_reg2_do_dm_read,
	input  logic                           in_reg2_do_dm_write,
	input  logic                           in_reg2_do_reg_write,
	output logic [cpu_pkg::data_w-1:0]     out_reg2_ra_data,
	output logic [cpu_pkg::data_w-1:0]     out_reg2_rt_data,
	output logic [cpu_pkg::data_w-1:0]     out_reg2_alu_src2,
	output cpu_pkg::opcode_e               out_reg2_opcode,
	output cpu_pkg::alu_op_e               out_reg2_alu_op,
	output logic [cpu_pkg::reg_idx_w-1:0]  out_reg2_wr_idx,
	output cpu_pkg::wb_sel_e               out_reg2_wb_sel,
	output logic                           out_reg2_do_dm_read,
	output logic                           out_reg2_do_dm_write,
	output logic                           out_reg2_do_reg_write,
	// REG3
	input  logic [cpu_pkg::data_w-1:0]     in_reg3_alu_result,
	input  logic                           in_reg3_alu_overflow,
	input  logic [cpu_pkg::data_w-1:0]     in_reg3_store_data,
	input  logic [cpu_pkg::reg_idx_w-1:0]  in_reg3_wr_idx,
	input  cpu_pkg::wb_sel_e               in_reg3_wb_sel,
	input  logic                           in_reg3_do_dm_read,
	input  logic                           in_reg3_do_dm_write,
	input  logic                           in_reg3_do_reg_write,
	output logic [cpu_pkg::data_w-1:0]     out_reg3_alu_result,
	output logic                           out_reg3_alu_overflow,
	output logic [cpu_pkg::data_w-1:0]     out_reg3_store_data,
	output logic [cpu_pkg::reg_idx_w-1:0]  out_reg3_wr_idx,
	output cpu_pkg::wb_sel_e               out_reg3_wb_sel,
	output logic                           out_reg3_do_dm_read,
	output logic                           out_reg3_do_dm_write,
	output logic                           out_reg3_do_reg_write,
	// REG4
	input  logic [cpu_pkg::data_w-1:0]     in_reg4_write_reg_data,
	input  logic                           in_reg4_overflow,
	input  logic [cpu_pkg::reg_idx_w-1:0]  in_reg4_wr_idx,
	input  logic                           in_reg4_do_reg_write,
	output logic [cpu_pkg::data_w-1:0]     out_reg4_write_reg_data,
	output logic                           out_reg4_overflow,
	output logic [cpu_pkg::reg_idx_w-1:0]  out_reg4_wr_idx,
	output logic                           out_reg4_do_reg_write
);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			out_reg1_valid          <= 1'b0;
			out_reg1_instr          <= '0;
			out_reg2_ra_data        <= '0;
			out_reg2_rt_data        <= '0;
			out_reg2_alu_src2       <= '0;
			out_reg2_opcode         <= cpu_pkg::op_alu;
			out_reg2_alu_op         <= cpu_pkg::alu_add;
			out_reg2_wr_idx         <= '0;
			out_reg2_wb_sel         <= cpu_pkg::wb_alu;
			out_reg2_do_dm_read     <= 1'b0;
			out_reg2_do_dm_write    <= 1'b0;
			out_reg2_do_reg_write   <= 1'b0;
			out_reg3_alu_result     <= '0;
			out_reg3_alu_overflow   <= 1'b0;
			out_reg3_store_data     <= '0;
			out_reg3_wr_idx         <= '0;
			out_reg3_wb_sel         <= cpu_pkg::wb_alu;
			out_reg3_do_dm_read     <= 1'b0;
			out_reg3_do_dm_write    <= 1'b0;
			out_reg3_do_reg_write   <= 1'b0;
			out_reg4_write_reg_data <= '0;
			out_reg4_overflow       <= 1'b0;
			out_reg4_wr_idx         <= '0;
			out_reg4_do_reg_write   <= 1'b0;
		end else begin
			if (!hold1) begin
				out_reg1_valid <= in_reg1_valid;
				out_reg1_instr <= in_reg1_instr;
			end

			out_reg2_ra_data      <= in_reg2_ra_data;
			out_reg2_rt_data      <= in_reg2_rt_data;
			out_reg2_alu_src2     <= in_reg2_alu_src2;
			out_reg2_opcode       <= in_reg2_opcode;
			out_reg2_alu_op       <= in_reg2_alu_op;
			out_reg2_wr_idx       <= in_reg2_wr_idx;
			out_reg2_wb_sel       <= in_reg2_wb_sel;
			out_reg2_do_dm_read   <= in_reg2_do_dm_read && !bubble2; // bubble kills controls.
			out_reg2_do_dm_write  <= in_reg2_do_dm_write && !bubble2;
			out_reg2_do_reg_write <= in_reg2_do_reg_write && !bubble2;

			out_reg3_alu_result   <= in_reg3_alu_result;
			out_reg3_alu_overflow <= in_reg3_alu_overflow;
			out_reg3_store_data   <= in_reg3_store_data;
			out_reg3_wr_idx       <= in_reg3_wr_idx;
			out_reg3_wb_sel       <= in_reg3_wb_sel;
			out_reg3_do_dm_read   <= in_reg3_do_dm_read;
			out_reg3_do_dm_write  <= in_reg3_do_dm_write;
			out_reg3_do_reg_write <= in_reg3_do_reg_write;

			out_reg4_write_reg_data <= in_reg4_write_reg_data;
			out_reg4_overflow       <= in_reg4_overflow;
			out_reg4_wr_idx         <= in_reg4_wr_idx;
			out_reg4_do_reg_write   <= in_reg4_do_reg_write;
		end
	end

endmodule

// ==== design/cpu_core.sv ====
`timescale 1ns/10ps

module cpu_core #(
	parameter int QUEUE_DEPTH = 4,
	parameter int DMEM_WORDS  = 64
) (
	input  logic        clock,
	input  logic        arst_n,
	input  logic        instr_valid,
	input  logic [31:0] instr,
	output logic        credit_return,
	output logic        wb_valid,
	output logic [4:0]  wb_reg,
	output logic [31:0] wb_data,
	output logic        wb_overflow
);
	logic                          pop_valid;
	logic [cpu_pkg::data_w-1:0]    pop_instr;
	logic                          stall;
	logic                          reg1_valid;
	logic [cpu_pkg::data_w-1:0]    reg1_instr;
	logic [cpu_pkg::reg_idx_w-1:0] ra_idx;
	logic [cpu_pkg::reg_idx_w-1:0] src2_idx;
	logic [cpu_pkg::data_w-1:0]    rf_ra_data;
	logic [cpu_pkg::data_w-1:0]    rf_src2_data;

	// decode outputs, REG2 inputs.
	logic [cpu_pkg::data_w-1:0]    dec_ra_data;
	logic [cpu_pkg::data_w-1:0]    dec_rt_data;
	logic [cpu_pkg::data_w-1:0]    dec_alu_src2;
	cpu_pkg::opcode_e              dec_opcode;
	cpu_pkg::alu_op_e              dec_alu_op;
	logic [cpu_pkg::reg_idx_w-1:0] dec_wr_idx;
	cpu_pkg::wb_sel_e              dec_wb_sel;
	logic                          dec_do_dm_read;
	logic                          dec_do_dm_write;
	logic                          dec_do_reg_write;

	// REG2 outputs.
	logic [cpu_pkg::data_w-1:0]    ex_ra_data;
	logic [cpu_pkg::data_w-1:0]    ex_rt_data;
	logic [cpu_pkg::data_w-1:0]    ex_alu_src2;
	cpu_pkg::opcode_e              ex_opcode;
	cpu_pkg::alu_op_e              ex_alu_op;
	logic [cpu_pkg::reg_idx_w-1:0] ex_wr_idx;
	cpu_pkg::wb_sel_e              ex_wb_sel;
	logic                          ex_do_dm_read;
	logic                          ex_do_dm_write;
	logic                          ex_do_reg_write;
	logic [cpu_pkg::data_w-1:0]    alu_result;
	logic                          alu_overflow;

	// REG3 outputs.
	logic [cpu_pkg::data_w-1:0]    res_alu_result;
	logic                          res_alu_overflow;
	logic [cpu_pkg::data_w-1:0]    res_store_data;
	logic [cpu_pkg::reg_idx_w-1:0] res_wr_idx;
	cpu_pkg::wb_sel_e              res_wb_sel;
	logic                          res_do_dm_read;
	logic                          res_do_dm_write;
	logic                          res_do_reg_write;
	logic [cpu_pkg::data_w-1:0]    write_reg_data;

	instr_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
		.clock(clock), .arst_n(arst_n),
		.instr_valid(instr_valid), .instr(instr), .stall(stall),
		.pop_valid(pop_valid), .pop_instr(pop_instr), .credit_return(credit_return)
	);

	// ex_is_load takes every pending write in execute, none of them is bypassable yet.
	decode_stage u_decode (
		.in_valid(reg1_valid), .instr(reg1_instr),
		.ra_idx(ra_idx), .src2_idx(src2_idx),
		.rf_ra_data(rf_ra_data), .rf_src2_data(rf_src2_data),
		.ex_is_load(ex_do_reg_write), .ex_wr_idx(ex_wr_idx),
		.res_do_reg_write(res_do_reg_write), .res_wr_idx(res_wr_idx), .res_data(write_reg_data),
		.wb_do_reg_write(wb_valid), .wb_wr_idx(wb_reg), .wb_data(wb_data),
		.opcode(dec_opcode), .alu_op(dec_alu_op), .wb_sel(dec_wb_sel),
		.ra_data(dec_ra_data), .rt_data(dec_rt_data), .alu_src2(dec_alu_src2),
		.wr_idx(dec_wr_idx), .do_dm_read(dec_do_dm_read), .do_dm_write(dec_do_dm_write),
		.do_reg_write(dec_do_reg_write), .stall(stall)
	);

	reg_file u_regs (
		.clock(clock), .arst_n(arst_n),
		.ra_idx(ra_idx), .src2_idx(src2_idx),
		.ra_data(rf_ra_data), .src2_data(rf_src2_data),
		.wr_en(wb_valid), .wr_idx(wb_reg), .wr_data(wb_data)
	);

	alu u_alu (
		.alu_op(ex_alu_op), .opcode(ex_opcode),
		.src1(ex_ra_data), .src2(ex_alu_src2),
		.result(alu_result), .overflow(alu_overflow)
	);

	result_stage #(.DMEM_WORDS(DMEM_WORDS)) u_result (
		.clock(clock), .alu_result(res_alu_result), .store_data(res_store_data),
		.do_dm_read(res_do_dm_read), .do_dm_write(res_do_dm_write),
		.wb_sel(res_wb_sel), .write_reg_data(write_reg_data)
	);

	pipe_walls u_walls (
		.clock(clock), .arst_n(arst_n), .hold1(stall), .bubble2(stall),
		.in_reg1_valid(pop_valid), .in_reg1_instr(pop_instr),
		.out_reg1_valid(reg1_valid), .out_reg1_instr(reg1_instr),
		.in_reg2_ra_data(dec_ra_data), .in_reg2_rt_data(dec_rt_data),
		.in_reg2_alu_src2(dec_alu_src2), .in_reg2_opcode(dec_opcode),
		.in_reg2_alu_op(dec_alu_op), .in_reg2_wr_idx(dec_wr_idx), .in_reg2_wb_sel(dec_wb_sel),
		.in_reg2_do_dm_read(dec_do_dm_read), .in_reg2_do_dm_write(dec_do_dm_write),
		.in_reg2_do_reg_write(dec_do_reg_write),
		.out_reg2_ra_data(ex_ra_data), .out_reg2_rt_data(ex_rt_data),
		.out_reg2_alu_src2(ex_alu_src2), .out_reg2_opcode(ex_opcode),
		.out_reg2_alu_op(ex_alu_op), .out_reg2_wr_idx(ex_wr_idx), .out_reg2_wb_sel(ex_wb_sel),
		.out_reg2_do_dm_read(ex_do_dm_read), .out_reg2_do_dm_write(ex_do_dm_write),
		.out_reg2_do_reg_write(ex_do_reg_write),
		.in_reg3_alu_result(alu_result), .in_reg3_alu_overflow(alu_overflow),
		.in_reg3_store_data(ex_rt_data), .in_reg3_wr_idx(ex_wr_idx),
		.in_reg3_wb_sel(ex_wb_sel), .in_reg3_do_dm_read(ex_do_dm_read),
		.in_reg3_do_dm_write(ex_do_dm_write), .in_reg3_do_reg_write(ex_do_reg_write),
		.out_reg3_alu_result(res_alu_result), .out_reg3_alu_overflow(res_alu_overflow),
		.out_reg3_store_data(res_store_data), .out_reg3_wr_idx(res_wr_idx),
		.out_reg3_wb_sel(res_wb_sel), .out_reg3_do_dm_read(res_do_dm_read),
		.out_reg3_do_dm_write(res_do_dm_write), .out_reg3_do_reg_write(res_do_reg_write),
		.in_reg4_write_reg_data(write_reg_data), .in_reg4_overflow(res_alu_overflow),
		.in_reg4_wr_idx(res_wr_idx), .in_reg4_do_reg_write(res_do_reg_write),
		.out_reg4_write_reg_data(wb_data), .out_reg4_overflow(wb_overflow),
		.out_reg4_wr_idx(wb_reg), .out_reg4_do_reg_write(wb_valid)
	);

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/10ps

module clock_gen (
	output logic clock,
	output logic arst_n
);
	initial begin
		clock  = 1'b0;
		arst_n = 1'b0;
		repeat (5) @(posedge clock);
		#1 arst_n = 1'b1; // released just after the fifth edge.
	end

	always #5 clock = ~clock;

endmodule

// ==== bench/cpu_core_tb.sv ====
`timescale 1ns/10ps

module cpu_core_tb;
	localparam int QUEUE_DEPTH = 4;
	localparam int TIMEOUT     = 500;

	logic        clock;
	logic        arst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic        credit_return;
	logic        wb_valid;
	logic [4:0]  wb_reg;
	logic [31:0] wb_data;
	logic        wb_overflow;

	logic [31:0] program_q [$];
	logic [4:0]  exp_reg_q [$];
	logic [31:0] exp_data_q [$];
	logic        exp_ovf_q [$];
	int          exp_total;
	int          credits;
	int          pushes;
	int          returns;
	int          wb_seen;
	int          errors;
	int          errors_before;
	int          tests_run;
	int          tests_failed;
	int          gap;
	integer      seed;
	bit          timed_out;

	clock_gen u_clock (
		.clock(clock),
		.arst_n(arst_n)
	);

	cpu_core #(
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.DMEM_WORDS(64)
	) DUT (
		.clock(clock), .arst_n(arst_n),
		.instr_valid(instr_valid), .instr(instr), .credit_return(credit_return),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data), .wb_overflow(wb_overflow)
	);

	task automatic load_stimulus();
		integer      fd;
		integer      rc;
		integer      ch;
		logic [7:0]  kind;
		logic [31:0] word;
		integer      reg_num;
		integer      ovf;
		fd = $fopen("bench/cpu_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open bench/cpu_stimulus.txt");
			errors++;
			return;
		end
		while ($fscanf(fd, " %c", kind) == 1) begin
			if (kind == "I") begin
				rc = $fscanf(fd, "%h", word);
				if (rc != 1) begin
					$display("stimulus file has an instruction record without a word");
					errors++;
				end else begin
					program_q.push_back(word);
				end
			end else if (kind == "E") begin
				rc = $fscanf(fd, "%d %h %d", reg_num, word, ovf);
				if (rc != 3) begin
					$display("stimulus file has an incomplete expected record");
					errors++;
				end else begin
					exp_reg_q.push_back(reg_num[4:0]);
					exp_data_q.push_back(word);
					exp_ovf_q.push_back(ovf[0]);
				end
			end else begin
				ch = 0;
				while (ch != 10 && ch != -1)
					ch = $fgetc(fd); // skip comment line.
			end
		end
		$fclose(fd);
	endtask

	task automatic check_writeback();
		logic [4:0]  exp_reg;
		logic [31:0] exp_data;
		logic        exp_ovf;
		wb_seen++;
		if (exp_reg_q.size() == 0) begin
			$display("write-back to r%0d at %0t has no expected record", wb_reg, $time);
			errors++;
			return;
		end
		exp_reg  = exp_reg_q.pop_front();
		exp_data = exp_data_q.pop_front();
		exp_ovf  = exp_ovf_q.pop_front();
		if (wb_reg !== exp_reg) begin
			$display("[FAIL] %0t wb_reg expected %0d actual %0d", $time, exp_reg, wb_reg);
			errors++;
		end
		if (wb_data !== exp_data) begin
			$display("[FAIL] %0t wb_data expected %h actual %h", $time, exp_data, wb_data);
			errors++;
		end
		if (wb_overflow !== exp_ovf) begin
			$display("[FAIL] %0t wb_overflow expected %b actual %b", $time, exp_ovf, wb_overflow);
			errors++;
		end
	endtask

	// outputs sampled mid-cycle.
	always @(negedge clock) begin
		if (arst_n && credit_return) begin
			credits++;
			returns++;
			if (credits > QUEUE_DEPTH) begin
				$display("more credits returned than instructions pushed at %0t", $time);
				errors++;
			end
		end
		if (arst_n && wb_valid)
			check_writeback();
	end

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		while (!arst_n) begin
			@(posedge clock);
			waited++;
			if (waited > TIMEOUT) begin
				$display("timeout while waiting for reset release");
				timed_out = 1'b1;
				errors++;
				return;
			end
		end
	endtask

	// called 1 ns after a rising edge.
	task automatic push_instr(input logic [31:0] word);
		int waited;
		waited = 0;
		while (credits == 0) begin
			@(posedge clock);
			#1;
			waited++;
			if (waited > TIMEOUT) begin
				$display("timeout: no credit came back for %0d cycles", TIMEOUT);
				timed_out = 1'b1;
				errors++;
				return;
			end
		end
		instr_valid = 1'b1;
		instr       = word;
		credits--;
		pushes++;
		@(posedge clock);
		#1;
		instr_valid = 1'b0;
	endtask

	task automatic drain_pipeline();
		int waited;
		waited = 0;
		while (exp_reg_q.size() > 0 || returns < pushes) begin
			@(posedge clock);
			waited++;
			if (waited > TIMEOUT) begin
				$display("timeout: %0d write-backs missing, %0d credits outstanding",
					exp_reg_q.size(), pushes - returns);
				timed_out = 1'b1;
				errors++;
				return;
			end
		end
		repeat (6) @(posedge clock); // last pop reaches write-back four edges later.
	endtask

	task automatic finish_test(input string name, input int errs_at_start);
		tests_run++;
		if (errors == errs_at_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errs_at_start);
		end
	endtask

	initial begin
		instr_valid  = 1'b0;
		instr        = '0;
		credits      = QUEUE_DEPTH;
		pushes       = 0;
		returns      = 0;
		wb_seen      = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		timed_out    = 1'b0;
		seed         = 32'h5de2;
		load_stimulus();
		exp_total = exp_reg_q.size();

		errors_before = errors;
		wait_reset_release();
		@(negedge clock);
		if (wb_valid !== 1'b0) begin
			$display("[FAIL] %0t wb_valid expected 0 actual %b", $time, wb_valid);
			errors++;
		end
		if (credit_return !== 1'b0) begin
			$display("[FAIL] %0t credit_return expected 0 actual %b", $time, credit_return);
			errors++;
		end
		finish_test("reset_state", errors_before);

		errors_before = errors;
		@(posedge clock);
		#1;
		for (int i = 0; i < program_q.size(); i++) begin
			gap = $random(seed) & 3;
			repeat (gap) begin
				@(posedge clock);
				#1;
			end
			if (!timed_out)
				push_instr(program_q[i]);
		end
		if (!timed_out)
			drain_pipeline();
		finish_test("program_writebacks", errors_before);

		errors_before = errors;
		if (returns != pushes) begin
			$display("[FAIL] %0t credit returns expected %0d actual %0d", $time, pushes, returns);
			errors++;
		end
		if (credits != QUEUE_DEPTH) begin
			$display("[FAIL] %0t credits expected %0d actual %0d", $time, QUEUE_DEPTH, credits);
			errors++;
		end
		finish_test("credit_balance", errors_before);

		errors_before = errors;
		if (wb_seen != exp_total) begin
			$display("[FAIL] %0t wb_valid pulses expected %0d actual %0d", $time, exp_total,
				wb_seen);
			errors++;
		end
		finish_test("writeback_count", errors_before);

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== bench/cpu_stimulus.txt ====
# I <instruction word, hex>
# E <destination register, decimal> <write-back data, hex> <overflow flag>
I 4417ffff
E 1 0007ffff 0
I 40108400
E 1 000ffffe 0
I 40108400
E 1 001ffffc 0
I 40108400
E 1 003ffff8 0
I 40108400
E 1 007ffff0 0
I 40108400
E 1 00ffffe0 0
I 40108400
E 1 01ffffc0 0
I 40108400
E 1 03ffff80 0
I 40108400
E 1 07ffff00 0
I 40108400
E 1 0ffffe00 0
I 40108400
E 1 1ffffc00 0
I 40108400
E 1 3ffff800 0
I 40108400
E 1 7ffff000 0
I 40208400
E 2 ffffe000 1
I 443ffffb
E 3 fffffffb 0
I 5041bffd
E 4 fffffff8 0
I 40520c01
E 5 fffffffd 0
I 40628402
E 6 7ffff000 0
I 40730c04
E 7 fffffffb 0
I 40839403
E 8 00000006 0
I 4093a006
E 9 00000001 0
I 7e000000
I 14800005
I 04a00005
E 10 00000006 0
I 40b52400
E 11 00000007 0
I 7e000000

// ==== cpu_core.f ====
common/cpu_pkg.sv
design/instr_queue.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/alu.sv
result/result_stage.sv
design/pipe_walls.sv
design/cpu_core.sv
bench/clock_gen.sv
bench/cpu_core_tb.sv
